//--- all.f
+incdir+logic
logic/serial_lcd_pkg.sv
logic/serial_lcd_if.sv
logic/baud_timer.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/lcd_writer.sv
logic/wb_regs.sv
logic/serial_lcd_top.sv
sim/tb_serial_lcd.sv

//--- Makefile
# Verilator build and run for the serial/LCD testbench

VERILATOR ?= verilator
TOP       ?= tb_serial_lcd
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Output goes to the console, status comes from the search
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_serial_lcd.sv
//////////////////////////////////////////////////
// Testbench for the serial/LCD peripheral
// Wishbone master, serial driver, line monitors
// Reference queues and typed compare tasks
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "serial_lcd_macros.svh"

module tb_serial_lcd;
   import serial_lcd_pkg::*;

   localparam int TX_COUNT = 20;
   localparam int RX_COUNT = 6;
   localparam int LCD_COUNT = 10;
   localparam int FRAME_CLKS = `SL_FRAME_BITS * `SL_BAUD_COUNT;
   localparam int LCD_CLKS = `SL_LCD_EN_CYCLES + `SL_LCD_SETTLE + 4;   // Load, next, margin
   localparam int CYCLE_LIMIT = 2 * (TX_COUNT + RX_COUNT) * FRAME_CLKS
                              + 2 * (`SL_INIT_COUNT + LCD_COUNT) * LCD_CLKS + 500;

   logic clk;
   logic reset;
   logic wb_cyc;
   logic wb_stb;
   logic wb_we;
   logic [1:0] wb_adr;
   bus_word_t wb_dat_w;
   bus_word_t wb_dat_r;
   logic wb_ack;
   logic uart_rxd;
   logic uart_txd;
   logic [7:0] lcd_data;
   logic lcd_rs;
   logic lcd_en;
   logic lcd_rw;

   integer seed;
   int cycles;
   int errors;
   logic [7:0] tx_seen[$];    // Bytes decoded off uart_txd
   logic [7:0] tx_exp[$];
   lcd_code_t lcd_seen[$];    // Codes at each lcd_en fall
   lcd_code_t lcd_exp[$];

   serial_lcd_top dut_i (
      .clk      (clk),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .uart_rxd (uart_rxd),
      .uart_txd (uart_txd),
      .lcd_data (lcd_data),
      .lcd_rs   (lcd_rs),
      .lcd_en   (lcd_en),
      .lcd_rw   (lcd_rw)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   // Run limit from frame and LCD write lengths
   initial
   begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      $display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $fatal(1, "Run stopped on timeout");
   end

   //////////////////////////////////////////////////
   // Compare and abort tasks
   //////////////////////////////////////////////////
   task automatic bus_word_cmp(input string name, input bus_word_t exp, input bus_word_t act);
      if (exp !== act)
      begin
         errors = errors + 1;
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         $display("TEST FAILED");
         $fatal(1, "Bus word mismatch");
      end
   endtask

   task automatic serial_byte_cmp(input string name, input logic [7:0] exp,
                                  input logic [7:0] act);
      if (exp !== act)
      begin
         errors = errors + 1;
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         $display("TEST FAILED");
         $fatal(1, "Serial byte mismatch");
      end
   endtask

   task automatic lcd_code_cmp(input string name, input lcd_code_t exp, input lcd_code_t act);
      if (exp !== act)
      begin
         errors = errors + 1;
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         $display("TEST FAILED");
         $fatal(1, "LCD code mismatch");
      end
   endtask

   task automatic line_level_cmp(input string name, input logic exp, input logic act);
      if (exp !== act)
      begin
         errors = errors + 1;
         $display("ERR %s: expected %b, actual %b", name, exp, act);
         $display("TEST FAILED");
         $fatal(1, "Line level mismatch");
      end
   endtask

   task automatic abort_run(input string what);
      errors = errors + 1;
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1, "Run aborted");
   endtask

   // HD44780 power-up commands with RS low
   function automatic lcd_code_t init_command(input int idx);
      case (idx)
         0, 1, 2, 3: return 9'h038;   // Function set
         4:          return 9'h00C;   // Display on
         5:          return 9'h001;   // Clear
         6:          return 9'h006;   // Entry mode
         default:    return 9'h080;   // Home address
      endcase
   endfunction

   //////////////////////////////////////////////////
   // Bus master and serial driver
   //////////////////////////////////////////////////
   task automatic bus_write(input reg_addr_e adr, input bus_word_t data);
      @(posedge clk);
      #1;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = 1'b1;
      wb_adr = adr;
      wb_dat_w = data;
      do
      begin
         @(posedge clk);
         #1;
      end
      while (wb_ack !== 1'b1);   // Back-pressure may stretch this
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
   endtask

   task automatic bus_read(input reg_addr_e adr, output bus_word_t data);
      @(posedge clk);
      #1;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = 1'b0;
      wb_adr = adr;
      do
      begin
         @(posedge clk);
         #1;
      end
      while (wb_ack !== 1'b1);
      data = wb_dat_r;   // Valid in the ack clock
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   task automatic wait_status(input int bit_idx, output bus_word_t word);
      do
         bus_read(STATUS, word);
      while (word[bit_idx] !== 1'b1);
   endtask

   task automatic send_serial(input logic [7:0] value);
      logic [9:0] frame;
      int n;
      frame = {1'b1, value, 1'b0};   // Stop, data, start
      @(posedge clk);
      #1;
      for (n = 0; n < 10; n++)
      begin
         uart_rxd = frame[n];
         repeat (`SL_BAUD_COUNT) @(posedge clk);
         #1;
      end
   endtask

   //////////////////////////////////////////////////
   // Line monitors
   //////////////////////////////////////////////////
   initial
   begin
      logic [7:0] tx_byte;
      int k;
      wait (reset === 1'b1);
      forever
      begin
         @(negedge uart_txd);
         repeat (`SL_BAUD_COUNT / 2) @(posedge clk);   // To mid start bit
         #1;
         line_level_cmp("tx_start_bit", 1'b0, uart_txd);
         for (k = 0; k < `SL_DATA_BITS; k++)
         begin
            repeat (`SL_BAUD_COUNT) @(posedge clk);
            #1;
            tx_byte[k] = uart_txd;   // LSB first
         end
         repeat (`SL_BAUD_COUNT) @(posedge clk);
         #1;
         line_level_cmp("tx_stop_bit", 1'b1, uart_txd);
         tx_seen.push_back(tx_byte);
      end
   end

   initial
   begin
      wait (reset === 1'b1);
      forever
      begin
         @(negedge lcd_en);
         lcd_seen.push_back({lcd_rs, lcd_data});
      end
   end

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////
   initial
   begin
      bus_word_t rd;
      logic [7:0] b;
      lcd_code_t code;
      integer rnd;
      int i;
      seed = 32'h2e0d_72ea;
      errors = 0;
      reset = 1'b0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = 2'd0;
      wb_dat_w = '0;
      uart_rxd = 1'b1;   // Idle line
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b1;

      // Idle levels while the init table still runs
      line_level_cmp("reset_uart_txd", 1'b1, uart_txd);
      line_level_cmp("reset_lcd_en", 1'b0, lcd_en);
      line_level_cmp("reset_lcd_rw", 1'b0, lcd_rw);
      line_level_cmp("reset_wb_ack", 1'b0, wb_ack);
      bus_read(STATUS, rd);
      bus_word_cmp("reset_status", 16'h0000, rd);

      // Power-up table
      while (lcd_seen.size() < `SL_INIT_COUNT) @(posedge clk);
      for (i = 0; i < `SL_INIT_COUNT; i++)
         lcd_code_cmp($sformatf("init_cmd_%0d", i), init_command(i), lcd_seen[i]);
      wait_status(3, rd);
      bus_word_cmp("init_status", 16'h0008, rd);
      if (lcd_seen.size() != `SL_INIT_COUNT)
         abort_run("LCD saw more than the init writes");

      // Back-to-back transmit writes
      for (i = 0; i < TX_COUNT; i++)
      begin
         rnd = $random(seed);
         b = rnd[7:0];
         tx_exp.push_back(b);
         bus_write(TX_DATA, {8'h00, b});
      end
      while (tx_seen.size() < TX_COUNT) @(posedge clk);
      for (i = 0; i < TX_COUNT; i++)
         serial_byte_cmp($sformatf("tx_byte_%0d", i), tx_exp[i], tx_seen[i]);

      // Ready flag set by a frame and cleared by the read
      for (i = 0; i < RX_COUNT; i++)
      begin
         rnd = $random(seed);
         b = rnd[7:0];
         send_serial(b);
         wait_status(2, rd);
         bus_word_cmp($sformatf("rx_status_%0d", i), 16'h000C, rd);
         bus_read(RX_DATA, rd);
         bus_word_cmp($sformatf("rx_first_%0d", i), {7'd0, 1'b1, b}, rd);
         bus_read(RX_DATA, rd);
         bus_word_cmp($sformatf("rx_second_%0d", i), {7'd0, 1'b0, b}, rd);
      end

      // Host LCD codes
      for (i = 0; i < LCD_COUNT; i++)
      begin
         rnd = $random(seed);
         code = rnd[8:0];
         lcd_exp.push_back(code);
         bus_write(LCD_CHAR, {7'd0, code});
         if (lcd_seen.size() != `SL_INIT_COUNT + i)
            abort_run("LCD write accepted before the previous one finished");
      end
      while (lcd_seen.size() < `SL_INIT_COUNT + LCD_COUNT) @(posedge clk);
      for (i = 0; i < LCD_COUNT; i++)
         lcd_code_cmp($sformatf("lcd_code_%0d", i), lcd_exp[i], lcd_seen[`SL_INIT_COUNT + i]);

      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/serial_lcd_top.sv
//////////////////////////////////////////////////
// Serial/LCD peripheral top level
// Wishbone slave, serial pins, LCD pins
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module serial_lcd_top (
   input  logic clk,
   input  logic reset,
   input  logic wb_cyc,
   input  logic wb_stb,
   input  logic wb_we,
   input  logic [1:0] wb_adr,
   input  logic [15:0] wb_dat_w,
   output logic [15:0] wb_dat_r,
   output logic wb_ack,
   input  logic uart_rxd,
   output logic uart_txd,
   output logic [7:0] lcd_data,
   output logic lcd_rs,
   output logic lcd_en,
   output logic lcd_rw
);
   import serial_lcd_pkg::*;

   uart_link uart_l ();
   lcd_link lcd_l ();

   wb_regs regs_i (
      .clk      (clk),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (reg_addr_e'(wb_adr)),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .uart     (uart_l.host),
      .lcd      (lcd_l.host)
   );

   uart_tx tx_i (.clk(clk), .reset(reset), .link(uart_l.tx), .uart_txd(uart_txd));

   uart_rx rx_i (.clk(clk), .reset(reset), .uart_rxd(uart_rxd), .link(uart_l.rx));

   lcd_writer lcd_i (
      .clk      (clk),
      .reset    (reset),
      .link     (lcd_l.writer),
      .lcd_data (lcd_data),
      .lcd_rs   (lcd_rs),
      .lcd_en   (lcd_en),
      .lcd_rw   (lcd_rw)
   );

endmodule

`default_nettype wire

//--- logic/wb_regs.sv
//////////////////////////////////////////////////
// Wishbone classic register slave
// Receive buffer and status word
// Transmit and LCD writes with ack back-pressure
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "serial_lcd_macros.svh"

module wb_regs (
   input  logic clk,
   input  logic reset,
   input  logic wb_cyc,
   input  logic wb_stb,
   input  logic wb_we,
   input  serial_lcd_pkg::reg_addr_e wb_adr,
   input  serial_lcd_pkg::bus_word_t wb_dat_w,
   output serial_lcd_pkg::bus_word_t wb_dat_r,
   output logic wb_ack,
   uart_link.host uart,
   lcd_link.host lcd
);
   import serial_lcd_pkg::*;

   logic access;      // Cycle open and not yet acked
   logic tx_stall;    // Transmitter still on the last byte
   logic lcd_stall;
   logic ack_next;
   logic rx_read;
   logic char_ready;
   logic [`SL_DATA_BITS-1:0] rx_buf;
   bus_word_t rd_word;

   assign access = wb_cyc && wb_stb && !wb_ack;
   assign tx_stall = wb_we && (wb_adr == TX_DATA) && uart.tx_busy;
   assign lcd_stall = wb_we && (wb_adr == LCD_CHAR) && !lcd.ready;
   assign ack_next = access && !tx_stall && !lcd_stall;
   assign rx_read = ack_next && !wb_we && (wb_adr == RX_DATA);

   // Pulses coincide with the ack edge
   assign uart.tx_load = ack_next && wb_we && (wb_adr == TX_DATA);
   assign uart.tx_data = wb_dat_w[`SL_DATA_BITS-1:0];
   assign lcd.start = ack_next && wb_we && (wb_adr == LCD_CHAR);
   assign lcd.code = wb_dat_w[$bits(lcd_code_t)-1:0];

   ///////////////////////////////////////////////
   // Read mux
   ///////////////////////////////////////////////
   always_comb
   begin
      case (wb_adr)
         RX_DATA: rd_word = bus_word_t'({char_ready, rx_buf});
         STATUS:  rd_word = bus_word_t'({lcd.ready, char_ready, uart.rx_busy, uart.tx_busy});
         default: rd_word = '0;   // Write-only words
      endcase
   end

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
         wb_ack <= 1'b0;
      else
         wb_ack <= ack_next;   // Single-clock ack
   end

   always_ff @(posedge clk)
   begin
      if (ack_next && !wb_we)
         wb_dat_r <= rd_word;
      if (uart.rx_done)
         rx_buf <= uart.rx_data;   // Unread byte is overwritten
   end

   // New character wins over a clearing read
   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
         char_ready <= 1'b0;
      else if (uart.rx_done)
         char_ready <= 1'b1;
      else if (rx_read)
         char_ready <= 1'b0;
   end

endmodule

`default_nettype wire

//--- logic/lcd_writer.sv
//////////////////////////////////////////////////
// Character LCD writer
// Power-up command table, host code writes
// Enable pulse and settle timing
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "serial_lcd_macros.svh"

module lcd_writer (
   input  logic clk,
   input  logic reset,
   lcd_link.writer link,
   output logic [7:0] lcd_data,
   output logic lcd_rs,
   output logic lcd_en,
   output logic lcd_rw
);
   import serial_lcd_pkg::*;

   localparam int IW = $clog2(`SL_INIT_COUNT + 1);
   localparam int TW = $clog2(`SL_LCD_EN_CYCLES + `SL_LCD_SETTLE);

   lcd_state_e state_q;
   logic [IW-1:0] init_idx;   // Next table entry
   logic [TW-1:0] tmr;
   logic init_done;
   logic take;                // Write starts this clock
   lcd_code_t init_code;

   ///////////////////////////////////////////////
   // Init table
   ///////////////////////////////////////////////
   always_comb
   begin
      case (int'(init_idx))
         0, 1, 2, 3: init_code = 9'h038;   // Function set, 8 bit, 2 lines
         4:          init_code = 9'h00C;   // Display on
         5:          init_code = 9'h001;   // Clear
         6:          init_code = 9'h006;   // Entry mode, increment
         default:    init_code = 9'h080;   // Home address
      endcase
   end

   assign init_done = (init_idx == IW'(`SL_INIT_COUNT));
   assign take = (state_q == LOAD) && (!init_done || link.start);

   ///////////////////////////////////////////////
   // Write sequencer
   ///////////////////////////////////////////////
   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
      begin
         state_q <= LOAD;
         init_idx <= '0;
         tmr <= '0;
      end
      else
         case (state_q)
            LOAD:
            begin
               tmr <= '0;
               if (take) state_q <= PULSE;
            end
            PULSE:   // First clock is data setup, then EN clocks high
            begin
               if (tmr == TW'(`SL_LCD_EN_CYCLES))
               begin
                  tmr <= '0;
                  state_q <= SETTLE;
               end
               else
                  tmr <= tmr + 1'b1;
            end
            SETTLE:
            begin
               if (tmr == TW'(`SL_LCD_SETTLE - 1))
                  state_q <= NEXT;
               tmr <= tmr + 1'b1;
            end
            NEXT:
            begin
               if (!init_done) init_idx <= init_idx + 1'b1;
               state_q <= LOAD;
            end
            default: state_q <= LOAD;
         endcase
   end

   // Code held at the pins until the next write
   always_ff @(posedge clk)
   begin
      if (take)
         {lcd_rs, lcd_data} <= init_done ? link.code : init_code;
   end

   assign lcd_en = (state_q == PULSE) && (tmr != '0);
   assign lcd_rw = 1'b0;                                  // Write only
   assign link.ready = init_done && (state_q == LOAD);

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
//////////////////////////////////////////////////
// Serial receiver
// Line sync, mid-bit sampling, byte on frame end
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "serial_lcd_macros.svh"

module uart_rx (
   input  logic clk,
   input  logic reset,
   input  logic uart_rxd,
   uart_link.rx link
);
   import serial_lcd_pkg::*;

   rx_state_e state_q;
   logic [1:0] sync_q;                  // Two-flop synchronizer
   logic rxd_s;
   logic restart;
   logic bit_mid;
   logic frame_end;
   logic [`SL_DATA_BITS:0] shift_q;     // Stop bit ends up on top
   logic [`SL_DATA_BITS-1:0] data_q;

   assign rxd_s = sync_q[1];

   // Counting starts on the first low sample, also straight out of DELIVER
   assign restart = (state_q != SHIFT) && rxd_s;

   baud_timer timer_i (
      .clk       (clk),
      .reset     (reset),
      .restart   (restart),
      .bit_end   (),
      .bit_mid   (bit_mid),
      .frame_end (frame_end)
   );

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
         sync_q <= 2'b11;   // Idle line level
      else
         sync_q <= {sync_q[0], uart_rxd};
   end

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
         state_q <= IDLE;
      else
         case (state_q)
            IDLE:    if (!rxd_s) state_q <= SHIFT;        // Start bit
            SHIFT:   if (frame_end) state_q <= DELIVER;
            DELIVER: state_q <= rxd_s ? IDLE : SHIFT;     // Back-to-back frame
            default: state_q <= IDLE;
         endcase
   end

   // Start sample falls off the bottom after ten shifts
   always_ff @(posedge clk)
   begin
      if (bit_mid)
         shift_q <= {rxd_s, shift_q[`SL_DATA_BITS:1]};
      if (frame_end)
         data_q <= shift_q[`SL_DATA_BITS-1:0];
   end

   assign link.rx_data = data_q;
   assign link.rx_done = (state_q == DELIVER);   // One clock
   assign link.rx_busy = (state_q == SHIFT);

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
//////////////////////////////////////////////////
// Serial transmitter
// Start bit, data LSB first, one stop bit
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "serial_lcd_macros.svh"

module uart_tx (
   input  logic clk,
   input  logic reset,
   uart_link.tx link,
   output logic uart_txd
);
   logic [`SL_DATA_BITS:0] shift_q;   // Data plus start bit in bit 0
   logic busy_q;
   logic bit_end;
   logic frame_end;

   // Timer runs only while a frame is out
   baud_timer timer_i (
      .clk       (clk),
      .reset     (reset),
      .restart   (!busy_q),
      .bit_end   (bit_end),
      .bit_mid   (),
      .frame_end (frame_end)
   );

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
         busy_q <= 1'b0;
      else if (link.tx_load)
         busy_q <= 1'b1;
      else if (frame_end)
         busy_q <= 1'b0;   // Stop bit done
   end

   // Shifts right, ones fill in behind for the stop bit
   always_ff @(posedge clk)
   begin
      if (link.tx_load)
         shift_q <= {link.tx_data, 1'b0};
      else if (bit_end)
         shift_q <= {1'b1, shift_q[`SL_DATA_BITS:1]};
   end

   // Registered line, idles high
   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
         uart_txd <= 1'b1;
      else
         uart_txd <= busy_q ? shift_q[0] : 1'b1;
   end

   assign link.tx_busy = busy_q;

endmodule

`default_nettype wire

//--- logic/baud_timer.sv
//////////////////////////////////////////////////
// Bit timer for serial frames
// Mid-bit and end-of-bit strobes, frame end flag
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "serial_lcd_macros.svh"

module baud_timer (
   input  logic clk,
   input  logic reset,
   input  logic restart,     // Holds both counters at zero
   output logic bit_end,
   output logic bit_mid,
   output logic frame_end
);
   localparam int CW = $clog2(`SL_BAUD_COUNT);
   localparam int BW = $clog2(`SL_FRAME_BITS);

   logic [CW-1:0] clk_cnt;   // Clocks within the bit
   logic [BW-1:0] bit_cnt;   // Bits within the frame

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
      begin
         clk_cnt <= '0;
         bit_cnt <= '0;
      end
      else if (restart)
      begin
         clk_cnt <= '0;
         bit_cnt <= '0;
      end
      else if (bit_end)
      begin
         clk_cnt <= '0;
         bit_cnt <= frame_end ? '0 : bit_cnt + 1'b1;   // Wrap after last bit
      end
      else
         clk_cnt <= clk_cnt + 1'b1;
   end

   // Strobes decoded from the count
   assign bit_end = !restart && (clk_cnt == CW'(`SL_BAUD_COUNT - 1));
   assign bit_mid = !restart && (clk_cnt == CW'(`SL_BAUD_COUNT / 2 - 1));
   assign frame_end = bit_end && (bit_cnt == BW'(`SL_FRAME_BITS - 1));

endmodule

`default_nettype wire

//--- logic/serial_lcd_if.sv
//////////////////////////////////////////////////
// uart_link: register block to transmitter/receiver
// lcd_link: register block to LCD writer
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "serial_lcd_macros.svh"

interface uart_link;
   logic [`SL_DATA_BITS-1:0] tx_data;
   logic tx_load;                       // One clock, only when idle
   logic tx_busy;
   logic [`SL_DATA_BITS-1:0] rx_data;   // Valid with rx_done
   logic rx_done;
   logic rx_busy;

   modport host (output tx_data, output tx_load, input tx_busy,
                 input rx_data, input rx_done, input rx_busy);
   modport tx (input tx_data, input tx_load, output tx_busy);
   modport rx (output rx_data, output rx_done, output rx_busy);
endinterface

interface lcd_link;
   import serial_lcd_pkg::*;
   lcd_code_t code;
   logic start;   // One clock, only while ready
   logic ready;   // Low through init and each write

   modport host (output code, output start, input ready);
   modport writer (input code, input start, output ready);
endinterface

`default_nettype wire

//--- logic/serial_lcd_pkg.sv
//////////////////////////////////////////////////
// Shared types for the serial/LCD peripheral
// Register map, FSM states, bus and LCD words
//////////////////////////////////////////////////
`default_nettype none

package serial_lcd_pkg;

   // Wishbone word addresses
   typedef enum logic [1:0] {
      TX_DATA  = 2'd0,
      RX_DATA  = 2'd1,
      STATUS   = 2'd2,
      LCD_CHAR = 2'd3
   } reg_addr_e;

   // Receiver FSM
   typedef enum logic [1:0] {IDLE, SHIFT, DELIVER} rx_state_e;

   // LCD write sequencer
   typedef enum logic [1:0] {LOAD, PULSE, SETTLE, NEXT} lcd_state_e;

   typedef logic [15:0] bus_word_t;   // Wishbone data
   typedef logic [8:0] lcd_code_t;    // Bit 8 is RS, 1 = character

endpackage

`default_nettype wire

//--- logic/serial_lcd_macros.svh
//////////////////////////////////////////////////
// Serial and LCD timing macros
// Baud count, character and frame widths
// LCD enable pulse and settle delays
//////////////////////////////////////////////////
`ifndef SERIAL_LCD_MACROS_SVH
`define SERIAL_LCD_MACROS_SVH

// Clocks per serial bit, small for simulation
`define SL_BAUD_COUNT 16
`define SL_DATA_BITS 8                      // Character width
`define SL_FRAME_BITS (`SL_DATA_BITS + 2)   // Start, data, stop

// LCD write timing in clocks
`define SL_LCD_EN_CYCLES 4
`define SL_LCD_SETTLE 20                    // Stands in for the ms wait
`define SL_INIT_COUNT 8                     // Power-up commands

`endif
